/* design/s16b_pkg.sv */
// System 16B main board shared definitions
// Region vector bit positions, PCB family encoding and the
// packed structs carried between the bus decode blocks

`default_nettype none

package s16b_pkg;

    // One-hot region vector from the bus mapper
    localparam int region_w    = 8;
    localparam int region_ram  = 3;
    localparam int region_oram = 4;
    localparam int region_vram = 5;
    localparam int region_pal  = 6;
    localparam int region_io   = 7;

    // Board family, decoded from the game identifier
    typedef enum logic [2:0] {
        pcb_5521       = 3'd0,  // also 5704 and the default
        pcb_5358_small = 3'd1,
        pcb_5358_large = 3'd2,
        pcb_5797       = 3'd3,
        pcb_korean     = 3'd4
    } s16b_pcb_e;

    // CPU bus as the board sees it
    typedef struct packed {
        logic [23:1] addr;
        logic        as_n;
        logic        uds_n;
        logic        lds_n;
        logic        rnw;
        logic [15:0] dout;
    } s16b_cpu_bus_t;

    // Registered chip selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic pal;
        logic objram;
        logic io;
    } s16b_cs_t;

    // Read data returned by the memories
    typedef struct packed {
        logic [15:0] ram;   // work RAM or video RAM, shared SDRAM port
        logic [15:0] rom;
        logic [15:0] chr;
        logic [15:0] pal;
        logic [15:0] obj;
        logic [7:0]  cab;
    } s16b_rd_src_t;

endpackage

`default_nettype wire

/* design/s16b_rom_bank.sv */
// Program ROM banking for the System 16B main board
// Decodes the PCB family from the game identifier and folds the
// low ROM regions into the banked SDRAM word address

`timescale 1ns/1ns
`default_nettype none

module s16b_rom_bank (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [23:1]                   addr,
    input  logic [s16b_pkg::region_w-1:0] active,
    input  logic [7:0]                    game_id,
    output s16b_pkg::s16b_pcb_e           pcb,
    output logic [17:0]                   rom_addr
);
    import s16b_pkg::*;

    logic       large_5358;
    logic [1:0] bank;

    // Large 5358 boards only differ by game code
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            large_5358 <= 1'b0;
        end else begin
            large_5358 <= (game_id == 8'h10) || (game_id == 8'h15) ||
                          (game_id == 8'h1a);
        end
    end

    // Family from the upper identifier bits
    always_comb begin
        casez (game_id[7:3])
            5'b001??: pcb = pcb_5797;
            5'b0001?: pcb = large_5358 ? pcb_5358_large : pcb_5358_small;
            5'b00001: pcb = pcb_korean;
            default:  pcb = pcb_5521;
        endcase
    end

    // Bank number from the three ROM regions
    always_comb begin
        case (active[2:0])
            3'b010:  bank = 2'd1;
            3'b100:  bank = 2'd2;
            default: bank = 2'd0;
        endcase
    end

    always_comb begin
        case (pcb)
            pcb_5797:       rom_addr = addr[18:1];
            pcb_5358_large: rom_addr = {bank, addr[16:1]};
            pcb_5358_small: rom_addr = {1'b0, bank, addr[15:1]};
            pcb_korean:     rom_addr = {1'b0, addr[17:1]};
            // 512kB map, only one bank bit reaches the ROM
            default:        rom_addr = {bank[0], addr[17:1]};
        endcase
    end

    // Mapper must never open two ROM banks at once
    a_rom_region_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(active[2:0])
    ) else $error("more than one ROM region active");

endmodule

`default_nettype wire

/* design/s16b_chip_select.sv */
// System 16B memory map decode
// Registered chip selects from the region vector, SDRAM acknowledge
// tracking with the busy level for the CPU, and the tile bank register

`timescale 1ns/1ns
`default_nettype none

module s16b_chip_select (
    input  logic                          clk,
    input  logic                          rst,
    input  s16b_pkg::s16b_cpu_bus_t       bus,
    input  logic [s16b_pkg::region_w-1:0] active,
    input  s16b_pkg::s16b_pcb_e           pcb,
    input  logic                          ram_ok,
    input  logic                          rom_ok,
    output s16b_pkg::s16b_cs_t            cs,
    output logic                          bus_busy,
    output logic [5:0]                    tile_bank
);
    import s16b_pkg::*;

    logic any_ds;
    logic wr_strobe;
    logic sample;
    logic is_5797;
    logic tbank_cs;
    logic sdram_ok;

    assign any_ds    = !(bus.uds_n && bus.lds_n);
    assign wr_strobe = any_ds && !bus.rnw;
    // Reads can open on the address strobe alone
    assign sample    = any_ds || (!bus.as_n && bus.rnw);
    assign is_5797   = (pcb == pcb_5797);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs       <= '0;
            tbank_cs <= 1'b0;
        end else if (sample) begin
            cs.rom    <= (is_5797 ? active[0] : |active[2:0]) && bus.rnw;
            cs.chr    <= active[region_vram] && bus.addr[16];
            cs.objram <= active[region_oram];
            cs.pal    <= active[region_pal];
            cs.io     <= active[region_io];
            // SDRAM requests need a data strobe so that a
            // read-modify-write toggles the select between halves
            cs.ram    <= any_ds && active[region_ram];
            cs.vram   <= any_ds && active[region_vram] && !bus.addr[16];
            if (is_5797) begin
                tbank_cs <= active[1] && (bus.addr[13:12] == 2'd2) && !bus.rnw;
            end else begin
                tbank_cs <= active[2] && !bus.rnw;
            end
        end else begin
            cs       <= '0;
            tbank_cs <= 1'b0;
        end
    end

    // Acknowledge holds until the address strobe releases
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram_ok <= 1'b0;
        end else if (bus.as_n) begin
            sdram_ok <= 1'b0;
        end else if (any_ds) begin
            sdram_ok <= cs.rom ? rom_ok : ram_ok;
        end
    end

    assign bus_busy = (cs.rom || cs.ram || cs.vram) && !sdram_ok;

    // Two 3-bit halves picked by address bit 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= 6'd0;
        end else if (tbank_cs && wr_strobe) begin
            if (bus.addr[1]) begin
                tile_bank[5:3] <= bus.dout[2:0];
            end else begin
                tile_bank[2:0] <= bus.dout[2:0];
            end
        end
    end

    // ROM select never stays up while a write is on the bus
    a_rom_read_only: assert property (
        @(posedge clk) disable iff (rst)
        cs.rom |-> bus.rnw
    ) else $error("ROM selected on a write");

    // Work RAM and video RAM share one SDRAM port
    a_ram_vram_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(cs.ram && cs.vram)
    ) else $error("work RAM and video RAM selected together");

endmodule

`default_nettype wire

/* design/s16b_read_mux.sv */
// CPU read data return
// Registers the data of the selected memory in fixed priority,
// open bus reads return all ones

`timescale 1ns/1ns
`default_nettype none

module s16b_read_mux (
    input  logic                   clk,
    input  logic                   rst,
    input  s16b_pkg::s16b_cs_t     cs,
    input  s16b_pkg::s16b_rd_src_t rd_src,
    output logic [15:0]            cpu_din
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 16'd0;
        end else begin
            if (cs.ram || cs.vram) begin
                cpu_din <= rd_src.ram;
            end else if (cs.rom) begin
                cpu_din <= rd_src.rom;
            end else if (cs.chr) begin
                cpu_din <= rd_src.chr;
            end else if (cs.pal) begin
                cpu_din <= rd_src.pal;
            end else if (cs.objram) begin
                cpu_din <= rd_src.obj;
            end else if (cs.io) begin
                // Cabinet inputs are byte wide
                cpu_din <= {8'hff, rd_src.cab};
            end else begin
                cpu_din <= 16'hffff;
            end
        end
    end

endmodule

`default_nettype wire

/* design/s16b_main_bus.sv */
// System 16B main board bus core
// ROM banking, memory map decode and CPU read return between the
// 68000 bus and the board memories

`timescale 1ns/1ns
`default_nettype none

module s16b_main_bus (
    input  logic                          clk,
    input  logic                          rst,
    input  s16b_pkg::s16b_cpu_bus_t       bus,
    input  logic [s16b_pkg::region_w-1:0] active,
    input  logic [7:0]                    game_id,
    input  logic                          ram_ok,
    input  logic                          rom_ok,
    input  s16b_pkg::s16b_rd_src_t        rd_src,
    output s16b_pkg::s16b_cs_t            cs,
    output logic [17:0]                   rom_addr,
    output logic [5:0]                    tile_bank,
    output logic                          bus_busy,
    output logic [15:0]                   cpu_din
);
    import s16b_pkg::*;

    s16b_pcb_e pcb;

    s16b_rom_bank u_rom_bank (
        .clk      (clk),
        .rst      (rst),
        .addr     (bus.addr),
        .active   (active),
        .game_id  (game_id),
        .pcb      (pcb),
        .rom_addr (rom_addr)
    );

    s16b_chip_select u_chip_select (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .active    (active),
        .pcb       (pcb),
        .ram_ok    (ram_ok),
        .rom_ok    (rom_ok),
        .cs        (cs),
        .bus_busy  (bus_busy),
        .tile_bank (tile_bank)
    );

    // Data sampled one cycle after the selects settle
    s16b_read_mux u_read_mux (
        .clk     (clk),
        .rst     (rst),
        .cs      (cs),
        .rd_src  (rd_src),
        .cpu_din (cpu_din)
    );

endmodule

`default_nettype wire

/* tests/tb_s16b_checks.svh */
// Result compares for the System 16B main bus testbench
// Each compare counts one check and reports a mismatch at once

`ifndef TB_S16B_CHECKS_SVH
`define TB_S16B_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_cs(input string name, input s16b_cs_t got, input s16b_cs_t want);
    check_count++;
    if (got !== want) begin
        $display("Error: %s = 0x%h, expected 0x%h", name, got, want);
        error_count++;
    end
endtask

task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] want);
    check_count++;
    if (got !== want) begin
        $display("Error: %s = 0x%h, expected 0x%h", name, got, want);
        error_count++;
    end
endtask

task automatic check_bank(input string name, input logic [5:0] got, input logic [5:0] want);
    check_count++;
    if (got !== want) begin
        $display("Error: %s = 0x%h, expected 0x%h", name, got, want);
        error_count++;
    end
endtask

task automatic check_rom_addr(input string name, input logic [17:0] got,
                              input logic [17:0] want);
    check_count++;
    if (got !== want) begin
        $display("Error: %s = 0x%h, expected 0x%h", name, got, want);
        error_count++;
    end
endtask

// Conditions that are not a single value
task automatic confirm(input logic ok, input string what);
    check_count++;
    if (!ok) begin
        $display("%s", what);
        error_count++;
    end
endtask

`endif

/* tests/tb_s16b_main.sv */
// Testbench for the System 16B main bus core
// Random bus traffic from a fixed seed, checked against a reference
// model of family decode, ROM banking, chip selects and read return

`timescale 1ns/1ns
`default_nettype none

module tb_s16b_main;
    import s16b_pkg::*;

    localparam int n_bank  = 16;
    localparam int n_rand  = 48;
    localparam int n_stall = 12;
    // Bank checks take 2 cycles, accesses 4, a stall at most 11
    localparam int cycle_limit =
        2 * (5 * (2 * n_bank + 2) + 4 * (2 * n_rand + 8) + 11 * n_stall + 4);

    logic                clk;
    logic                rst;
    s16b_cpu_bus_t       bus;
    logic [region_w-1:0] active;
    logic [7:0]          game_id;
    logic                ram_ok;
    logic                rom_ok;
    s16b_rd_src_t        rd_src;
    s16b_cs_t            cs;
    logic [17:0]         rom_addr;
    logic [5:0]          tile_bank;
    logic                bus_busy;
    logic [15:0]         cpu_din;
    integer              seed;
    int                  cycles;
    int                  mark;
    logic [5:0]          exp_bank;
    // 5521, 5358 small, 5358 large, 5797, Korean
    logic [7:0]          family_ids [5] = '{8'h42, 8'h11, 8'h15, 8'h2c, 8'h0a};

    `include "tb_s16b_checks.svh"

    s16b_main_bus u_s16b_main_bus (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Timeout: run stopped after %0d cycles", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic s16b_pcb_e decode_pcb(input logic [7:0] id);
        if (id == 8'h10 || id == 8'h15 || id == 8'h1a)
            return pcb_5358_large;
        if (id >= 8'h20 && id <= 8'h3f)
            return pcb_5797;
        if (id >= 8'h10 && id <= 8'h1f)
            return pcb_5358_small;
        if (id >= 8'h08 && id <= 8'h0f)
            return pcb_korean;
        return pcb_5521;
    endfunction

    function automatic logic [17:0] banked_rom_addr(input s16b_pcb_e p, input logic [23:1] a,
                                                    input logic [7:0] act);
        logic [1:0] bank;
        bank = act[1] ? 2'd1 : (act[2] ? 2'd2 : 2'd0);
        case (p)
            pcb_5797:       return a[18:1];
            pcb_5358_large: return {bank, a[16:1]};
            pcb_5358_small: return {1'b0, bank, a[15:1]};
            pcb_korean:     return {1'b0, a[17:1]};
            default:        return {bank[0], a[17:1]};
        endcase
    endfunction

    function automatic s16b_cs_t expected_cs(input logic is_5797, input s16b_cpu_bus_t b,
                                             input logic [7:0] act);
        s16b_cs_t c;
        logic     ds;
        c  = '0;
        ds = !b.uds_n || !b.lds_n;
        if (ds || (!b.as_n && b.rnw)) begin
            c.rom    = b.rnw && (is_5797 ? act[0] : (act[0] || act[1] || act[2]));
            c.ram    = ds && act[region_ram];
            c.vram   = ds && act[region_vram] && !b.addr[16];
            c.chr    = act[region_vram] && b.addr[16];
            c.objram = act[region_oram];
            c.pal    = act[region_pal];
            c.io     = act[region_io];
        end
        return c;
    endfunction

    function automatic logic [15:0] expected_din(input s16b_cs_t c, input s16b_rd_src_t s);
        if (c.ram || c.vram)
            return s.ram;
        if (c.rom)
            return s.rom;
        if (c.chr)
            return s.chr;
        if (c.pal)
            return s.pal;
        if (c.objram)
            return s.obj;
        if (c.io)
            return {8'hff, s.cab};
        return 16'hffff;
    endfunction

    // One bus cycle with select, read data and tile bank checks before release
    task automatic bus_access(input s16b_cpu_bus_t b, input logic [7:0] act);
        s16b_cs_t    exp_cs;
        logic [31:0] r;
        logic        is_5797;
        is_5797 = (decode_pcb(game_id) == pcb_5797);
        @(negedge clk);
        bus    = b;
        active = act;
        r = next_random();
        rd_src.ram = r[15:0];
        rd_src.rom = r[31:16];
        r = next_random();
        rd_src.chr = r[15:0];
        rd_src.pal = r[31:16];
        r = next_random();
        rd_src.obj = r[15:0];
        rd_src.cab = r[23:16];
        exp_cs = expected_cs(is_5797, b, act);
        @(negedge clk);
        check_cs("cs", cs, exp_cs);
        @(negedge clk);
        check_word("cpu_din", cpu_din, expected_din(exp_cs, rd_src));
        if (!(b.uds_n && b.lds_n) && !b.rnw &&
            (is_5797 ? (act[1] && b.addr[13:12] == 2'd2) : act[2])) begin
            if (b.addr[1])
                exp_bank[5:3] = b.dout[2:0];
            else
                exp_bank[2:0] = b.dout[2:0];
        end
        check_bank("tile_bank", tile_bank, exp_bank);
        bus.as_n  = 1'b1;
        bus.uds_n = 1'b1;
        bus.lds_n = 1'b1;
        @(negedge clk);
        check_cs("cs", cs, '0);
    endtask

    task automatic random_access(input logic reads_only);
        s16b_cpu_bus_t b;
        logic [31:0]   r;
        logic [7:0]    act;
        r = next_random();
        b.addr = r[22:0];
        b.rnw  = reads_only || r[23];
        b.as_n = 1'b0;
        {b.uds_n, b.lds_n} = r[25:24];
        act = (r[28:27] == 2'd0) ? 8'd0 : 8'd1 << r[31:29];
        r = next_random();
        b.dout = r[15:0];
        bus_access(b, act);
    endtask

    task automatic tile_write(input int region, input logic hi, input logic [1:0] sel);
        s16b_cpu_bus_t b;
        logic [31:0]   r;
        r = next_random();
        b = '0;
        b.addr = r[22:0];
        b.addr[13:12] = sel;
        b.addr[1] = hi;
        b.dout = r[31:16];
        // Data always differs from the half it aims at
        b.dout[2:0] = hi ? ~exp_bank[5:3] : ~exp_bank[2:0];
        bus_access(b, 8'd1 << region);
    endtask

    // SDRAM acknowledge withheld for a random number of cycles
    task automatic stall_access(input logic rom_side);
        s16b_cpu_bus_t b;
        logic [31:0]   r;
        int            hold;
        r = next_random();
        hold = 1 + int'(r[26:24]);
        b = '0;
        b.addr = r[22:0];
        b.rnw  = rom_side || r[23];
        @(negedge clk);
        ram_ok = 1'b0;
        rom_ok = 1'b0;
        bus    = b;
        active = rom_side ? 8'd1 : 8'd1 << region_ram;
        repeat (hold) begin
            @(negedge clk);
            confirm(bus_busy, "bus_busy dropped while the SDRAM acknowledge was withheld");
        end
        if (rom_side)
            rom_ok = 1'b1;
        else
            ram_ok = 1'b1;
        @(negedge clk);
        confirm(!bus_busy, "bus_busy still high one cycle after the acknowledge rose");
        bus.as_n  = 1'b1;
        bus.uds_n = 1'b1;
        bus.lds_n = 1'b1;
        ram_ok = 1'b1;
        rom_ok = 1'b1;
        @(negedge clk);
        confirm(!bus_busy, "bus_busy high while the address strobe is released");
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, error_count - errs_before);
    endtask

    initial begin
        logic [31:0] r;
        seed     = 21;
        exp_bank = 6'd0;
        rst      = 1'b1;
        bus      = '0;
        bus.as_n  = 1'b1;
        bus.uds_n = 1'b1;
        bus.lds_n = 1'b1;
        bus.rnw   = 1'b1;
        active   = '0;
        game_id  = 8'h42;
        ram_ok   = 1'b1;
        rom_ok   = 1'b1;
        rd_src   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        mark = error_count;
        check_cs("cs", cs, '0);
        check_word("cpu_din", cpu_din, 16'h0000);
        check_bank("tile_bank", tile_bank, 6'd0);
        confirm(!bus_busy, "bus_busy high during reset");
        rst = 1'b0;
        report_test("test 1 reset", mark);

        mark = error_count;
        for (int f = 0; f < 5; f++) begin
            @(negedge clk);
            game_id = family_ids[f];
            // Large 5358 flag is registered
            @(negedge clk);
            for (int i = 0; i < n_bank; i++) begin
                r = next_random();
                @(negedge clk);
                bus.addr = r[22:0];
                active = (r[24:23] == 2'd3) ? 8'd0 : 8'd1 << r[24:23];
                @(negedge clk);
                check_rom_addr("rom_addr", rom_addr,
                               banked_rom_addr(decode_pcb(game_id), bus.addr, active));
            end
        end
        report_test("test 2 rom banking", mark);

        mark = error_count;
        for (int i = 0; i < n_rand; i++) begin
            game_id = i[0] ? 8'h2c : 8'h42;
            random_access(1'b0);
        end
        report_test("test 3 chip selects", mark);

        mark = error_count;
        for (int i = 0; i < n_rand; i++)
            random_access(1'b1);
        report_test("test 4 read return", mark);

        mark = error_count;
        game_id = 8'h2c;
        tile_write(1, 1'b0, 2'd2);
        tile_write(1, 1'b1, 2'd2);
        tile_write(2, 1'b0, 2'd2);
        tile_write(1, 1'b1, 2'd1);
        game_id = 8'h42;
        tile_write(2, 1'b0, 2'd0);
        tile_write(2, 1'b1, 2'd3);
        tile_write(1, 1'b0, 2'd2);
        tile_write(region_ram, 1'b1, 2'd0);
        report_test("test 5 tile bank", mark);

        mark = error_count;
        for (int i = 0; i < n_stall; i++)
            stall_access(i[0]);
        report_test("test 6 sdram back-pressure", mark);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+tests
design/s16b_pkg.sv
design/s16b_rom_bank.sv
design/s16b_chip_select.sv
design/s16b_read_mux.sv
design/s16b_main_bus.sv
tests/tb_s16b_main.sv

/* Makefile */
# Verilator build and run of the System 16B main bus testbench

obj_dir/Vtb_s16b_main: build.f $(wildcard design/*.sv tests/*.sv tests/*.svh)
	verilator --binary --timing --assert -f build.f --top-module tb_s16b_main

run: obj_dir/Vtb_s16b_main
	@out=$$(./obj_dir/Vtb_s16b_main); echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
